// ==== filelist.f ====
verilog/rpi_bus_pkg.sv
verilog/memory_map_pkg.sv
verilog/half_duplex_rpi_bus.sv
verilog/edge_logger.sv
verilog/bank_arbiter.sv
verilog/banked_ram.sv
verilog/pollable_memory.sv
dv/tb_clock_gen.sv
dv/tb_pollable_memory.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f filelist.f \
	--top-module tb_pollable_memory \
	-Mdir obj_dir -o tb_pollable_memory

./obj_dir/tb_pollable_memory > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
	echo "run_sim: testbench reported a failure"
	exit 1
fi
echo "run_sim: no failure in sim.log"

// ==== dv/tb_pollable_memory.sv ====
`default_nettype none

module tb_pollable_memory
	import rpi_bus_pkg::*, memory_map_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int BUS_W = bus_width_default;
	localparam int DATA_W = data_width_default;
	localparam int BANK_BITS = log2_number_of_banks_default;
	localparam int WORD_BITS = bank_address_depth_default;
	localparam int WORDS_PER_BANK = 4;
	localparam int LOG_EVENTS = 4;
	localparam int LOG_SCAN = 16;
	localparam int BURST_WORDS = 12;
	localparam int CONTENTION_EVENTS = 6;
	// bus transactions of every test, in run order
	localparam int TRANSACTIONS = (1 + 2 * LOG_SCAN) + 2
		+ 7 * (2 + 4 * WORDS_PER_BANK) + 12 + (1 + 2 * LOG_EVENTS)
		+ (2 + 4 * BURST_WORDS) + (1 + 2 * (LOG_SCAN - LOG_EVENTS));
	localparam int TIMEOUT_CYCLES = TRANSACTIONS * 40 + 1000;
	// channels pulsed while the bus is idle, one record each
	localparam logic [channel_count-1:0] IDLE_MASKS [LOG_EVENTS] =
		'{4'b0001, 4'b0100, 4'b1010, 4'b1000};

	logic clock;
	logic arst_n;
	logic [BUS_W-1:0] bus_in;
	logic [BUS_W-1:0] bus_out;
	logic bus_oe;
	logic read;
	logic register_select;
	logic enable;
	logic ack_valid;
	logic [channel_count-1:0] coax_in;

	int seed = 32'h6416_7c14;
	// reference memory, keyed by full address word
	logic [DATA_W-1:0] memory_model [logic [BUS_W-1:0]];
	logic [BUS_W-1:0] model_address;
	// read halves waiting for the compare process
	logic [BUS_W-1:0] sampled_buf [0:511];
	logic [BUS_W-1:0] expected_buf [0:511];
	string label_buf [0:511];
	int produced = 0;
	int consumed = 0;
	int inline_checks = 0;
	int inline_errors = 0;
	int compare_checks = 0;
	int compare_errors = 0;
	int cycle_count = 0;

	tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(4)) clock_gen (
		.clock(clock), .arst_n(arst_n)
	);

	pollable_memory DUT (
		.clock(clock), .arst_n(arst_n),
		.bus_in(bus_in), .bus_out(bus_out), .bus_oe(bus_oe),
		.read(read), .register_select(register_select), .enable(enable),
		.ack_valid(ack_valid), .coax_in(coax_in)
	);

	// ------------------------------
	// reference model
	// ------------------------------
	// high half is index 0
	function automatic logic [BUS_W-1:0] expected_half(input logic [DATA_W-1:0] word,
			input int index);
		return word[DATA_W-1 - index * BUS_W -: BUS_W];
	endfunction

	// plain increment, carries into bank bits
	function automatic logic [BUS_W-1:0] next_address(input logic [BUS_W-1:0] address);
		return address + 1'b1;
	endfunction

	function automatic logic [BUS_W-1:0] bank_word_address(input int bank, input int word);
		return {BANK_BITS'(bank), WORD_BITS'(word)};
	endfunction

	// ------------------------------
	// host bus tasks
	// ------------------------------
	// one level handshake, enable held until ack
	task automatic bus_cycle(input logic dir, input logic sel, input logic [BUS_W-1:0] value,
			output logic [BUS_W-1:0] sampled);
		@(posedge clock);
		read <= dir;
		register_select <= sel;
		bus_in <= value;
		@(posedge clock);
		enable <= 1'b1;
		do @(posedge clock); while (ack_valid !== 1'b1);
		sampled = bus_out;
		if (dir == read_dir) begin
			assert (bus_oe === 1'b1) else begin
				inline_errors++;
				$display("ERROR @ %0t: bus_oe low during read acknowledge", $time);
			end
			inline_checks++;
		end
		enable <= 1'b0;
		do @(posedge clock); while (ack_valid !== 1'b0);
	endtask

	task automatic expect_read(input logic [BUS_W-1:0] sampled,
			input logic [BUS_W-1:0] expected, input string what);
		sampled_buf[produced] = sampled;
		expected_buf[produced] = expected;
		label_buf[produced] = what;
		produced++;
	endtask

	task automatic write_address(input logic [BUS_W-1:0] address);
		logic [BUS_W-1:0] ignored;
		bus_cycle(write_dir, select_address, address, ignored);
		model_address = address;
	endtask

	task automatic check_address();
		logic [BUS_W-1:0] sampled;
		bus_cycle(read_dir, select_address, '0, sampled);
		expect_read(sampled, model_address, "address register");
	endtask

	task automatic write_word(input logic [DATA_W-1:0] word);
		logic [BUS_W-1:0] ignored;
		for (int h = 0; h < DATA_W / BUS_W; h++) begin
			bus_cycle(write_dir, select_data, expected_half(word, h), ignored);
		end
		memory_model[model_address] = word;
		model_address = next_address(model_address);
	endtask

	// raw word, for log records
	task automatic read_word(output logic [DATA_W-1:0] word);
		logic [BUS_W-1:0] sampled;
		word = '0;
		for (int h = 0; h < DATA_W / BUS_W; h++) begin
			bus_cycle(read_dir, select_data, '0, sampled);
			word = {word[DATA_W-BUS_W-1:0], sampled};
		end
		model_address = next_address(model_address);
	endtask

	task automatic check_word();
		logic [BUS_W-1:0] address;
		logic [BUS_W-1:0] sampled;
		address = model_address;
		for (int h = 0; h < DATA_W / BUS_W; h++) begin
			bus_cycle(read_dir, select_data, '0, sampled);
			expect_read(sampled, expected_half(memory_model[address], h),
				$sformatf("word 0x%04h half %0d", address, h));
		end
		model_address = next_address(model_address);
	endtask

	task automatic pulse_coax(input logic [channel_count-1:0] mask, input int gap);
		@(posedge clock);
		coax_in <= mask;
		repeat (3) @(posedge clock);
		coax_in <= '0;
		repeat (gap) @(posedge clock);
	endtask

	// ------------------------------
	// compare and timeout
	// ------------------------------
	always @(posedge clock) begin : compare_reads
		while (consumed < produced) begin
			assert (sampled_buf[consumed] === expected_buf[consumed]) else begin
				compare_errors++;
				$display("ERROR @ %0t: %s read 0x%04h, expected 0x%04h", $time,
					label_buf[consumed], sampled_buf[consumed], expected_buf[consumed]);
			end
			compare_checks++;
			consumed++;
		end
	end

	always @(posedge clock) begin : watchdog
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout: %0d cycles passed and the bus tests did not finish", cycle_count);
			$display("Verification failed");
			$finish;
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin : stimulus
		logic [DATA_W-1:0] word;
		logic [timestamp_width-1:0] previous_stamp;
		int nonzero_records;
		read <= write_dir;
		register_select <= select_address;
		enable <= 1'b0;
		bus_in <= '0;
		coax_in <= '0;
		model_address = '0;
		previous_stamp = '0;
		wait (arst_n === 1'b1);
		repeat (3) @(posedge clock);

		// quiet bus after reset
		assert (ack_valid === 1'b0 && bus_oe === 1'b0) else begin
			inline_errors++;
			$display("ERROR @ %0t: ack_valid or bus_oe high after reset", $time);
		end
		inline_checks++;

		// zero the log region so empty records read as mask 0
		write_address(bank_word_address(log_bank, 0));
		repeat (LOG_SCAN) write_word('0);

		// address register round trip
		write_address(16'h1234);
		check_address();

		// random words into banks 0 to 6, then read back
		for (int b = 0; b < 7; b++) begin
			write_address(bank_word_address(b, b * 37));
			for (int w = 0; w < WORDS_PER_BANK; w++) begin
				word = $random(seed);
				write_word(word);
			end
		end
		for (int b = 0; b < 7; b++) begin
			write_address(bank_word_address(b, b * 37));
			repeat (WORDS_PER_BANK) check_word();
		end

		// last word of bank 2, next one lands in bank 3
		write_address(bank_word_address(2, (1 << WORD_BITS) - 1));
		repeat (2) begin
			word = $random(seed);
			write_word(word);
		end
		check_address();
		write_address(bank_word_address(2, (1 << WORD_BITS) - 1));
		check_word();
		write_address(bank_word_address(3, 0));
		check_word();

		// separated edges, bus idle
		for (int i = 0; i < LOG_EVENTS; i++) begin
			pulse_coax(IDLE_MASKS[i], 24);
		end
		repeat (8) @(posedge clock);
		write_address(bank_word_address(log_bank, 0));
		for (int i = 0; i < LOG_EVENTS; i++) begin
			read_word(word);
			assert (word[channel_count-1:0] === IDLE_MASKS[i]) else begin
				inline_errors++;
				$display("ERROR @ %0t: log record %0d mask %b, expected %b", $time, i,
					word[channel_count-1:0], IDLE_MASKS[i]);
			end
			inline_checks++;
			if (i > 0) begin
				assert (word[DATA_W-1 -: timestamp_width] > previous_stamp) else begin
					inline_errors++;
					$display("ERROR @ %0t: log record %0d timestamp not increasing", $time, i);
				end
				inline_checks++;
			end
			previous_stamp = word[DATA_W-1 -: timestamp_width];
		end

		// host burst with coax edges on top
		fork
			begin
				write_address(bank_word_address(5, 256));
				for (int w = 0; w < BURST_WORDS; w++) begin
					word = $random(seed);
					write_word(word);
				end
				write_address(bank_word_address(5, 256));
				repeat (BURST_WORDS) check_word();
			end
			begin
				// one edge per word write, log request lands with the host request
				repeat (21) @(posedge clock);
				for (int e = 0; e < CONTENTION_EVENTS; e++) begin
					pulse_coax(channel_count'(1) << (e % channel_count), 17);
				end
			end
		join
		repeat (8) @(posedge clock);
		write_address(bank_word_address(log_bank, LOG_EVENTS));
		nonzero_records = 0;
		for (int i = LOG_EVENTS; i < LOG_SCAN; i++) begin
			read_word(word);
			if (word[channel_count-1:0] != '0) begin
				nonzero_records++;
			end
		end
		assert (nonzero_records == CONTENTION_EVENTS) else begin
			inline_errors++;
			$display("ERROR @ %0t: %0d log records under contention, expected %0d", $time,
				nonzero_records, CONTENTION_EVENTS);
		end
		inline_checks++;

		// let the compare process catch up
		while (consumed < produced) @(posedge clock);
		@(posedge clock);
		$display("checks: %0d, errors: %0d", inline_checks + compare_checks,
			inline_errors + compare_errors);
		if (inline_errors + compare_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 4
) (
	output logic clock,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// free-running clock, starts low
	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2.0) clock = ~clock;
	end

	// reset held for a few edges, released on a rising edge
	initial begin
		arst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== verilog/pollable_memory.sv ====
`default_nettype none

module pollable_memory
	import rpi_bus_pkg::*, memory_map_pkg::*;
#(
	parameter int BUS_WIDTH = bus_width_default,
	parameter int DATA_WIDTH = BUS_WIDTH * transactions_per_data_word_default,
	parameter int LOG2_OF_NUMBER_OF_BANKS = log2_number_of_banks_default,
	// 16 - 3 = 13
	parameter int BANK_ADDRESS_DEPTH = BUS_WIDTH - LOG2_OF_NUMBER_OF_BANKS,
	parameter bit ADDRESS_AUTOINCREMENT_MODE = 1'b1,
	localparam int ADDRESS_WIDTH = BANK_ADDRESS_DEPTH + LOG2_OF_NUMBER_OF_BANKS
) (
	input wire clock,
	input wire arst_n,
	input wire [BUS_WIDTH-1:0] bus_in,
	output logic [BUS_WIDTH-1:0] bus_out,
	output logic bus_oe,
	input wire read,
	input wire register_select,
	input wire enable,
	output logic ack_valid,
	input wire [channel_count-1:0] coax_in
);
	logic host_request;
	logic host_write;
	logic [ADDRESS_WIDTH-1:0] host_address;
	logic [DATA_WIDTH-1:0] host_write_data;
	logic host_grant;
	logic host_read_valid;
	logic log_request;
	logic [ADDRESS_WIDTH-1:0] log_address;
	log_record_t log_record;
	logic log_grant;
	logic mem_enable;
	logic mem_write;
	logic [ADDRESS_WIDTH-1:0] mem_address;
	logic [DATA_WIDTH-1:0] mem_write_data;
	logic [DATA_WIDTH-1:0] read_data;

	// ------------------------------
	// host side and logger
	// ------------------------------
	half_duplex_rpi_bus #(
		.BUS_WIDTH(BUS_WIDTH), .DATA_WIDTH(DATA_WIDTH),
		.BANK_ADDRESS_DEPTH(BANK_ADDRESS_DEPTH),
		.LOG2_OF_NUMBER_OF_BANKS(LOG2_OF_NUMBER_OF_BANKS),
		.ADDRESS_AUTOINCREMENT_MODE(ADDRESS_AUTOINCREMENT_MODE)
	) hdrb (
		.clock(clock), .arst_n(arst_n),
		.bus_in(bus_in), .bus_out(bus_out), .bus_oe(bus_oe),
		.read(read), .register_select(register_select), .enable(enable),
		.ack_valid(ack_valid),
		.host_request(host_request), .host_write(host_write),
		.host_address(host_address), .host_write_data(host_write_data),
		.host_grant(host_grant), .host_read_valid(host_read_valid),
		.read_data(read_data)
	);

	edge_logger #(
		.BANK_ADDRESS_DEPTH(BANK_ADDRESS_DEPTH),
		.LOG2_OF_NUMBER_OF_BANKS(LOG2_OF_NUMBER_OF_BANKS)
	) logger (
		.clock(clock), .arst_n(arst_n), .coax_in(coax_in),
		.log_request(log_request), .log_address(log_address),
		.log_record(log_record), .log_grant(log_grant)
	);

	// ------------------------------
	// shared memory
	// ------------------------------
	bank_arbiter #(
		.DATA_WIDTH(DATA_WIDTH), .BANK_ADDRESS_DEPTH(BANK_ADDRESS_DEPTH),
		.LOG2_OF_NUMBER_OF_BANKS(LOG2_OF_NUMBER_OF_BANKS)
	) arbiter (
		.clock(clock), .arst_n(arst_n),
		.host_request(host_request), .host_write(host_write),
		.host_address(host_address), .host_write_data(host_write_data),
		.host_grant(host_grant), .host_read_valid(host_read_valid),
		.log_request(log_request), .log_address(log_address),
		.log_record(log_record), .log_grant(log_grant),
		.mem_enable(mem_enable), .mem_write(mem_write),
		.mem_address(mem_address), .mem_write_data(mem_write_data)
	);

	banked_ram #(
		.DATA_WIDTH(DATA_WIDTH), .BANK_ADDRESS_DEPTH(BANK_ADDRESS_DEPTH),
		.LOG2_OF_NUMBER_OF_BANKS(LOG2_OF_NUMBER_OF_BANKS)
	) ram (
		.clock(clock), .mem_enable(mem_enable), .mem_write(mem_write),
		.mem_address(mem_address), .mem_write_data(mem_write_data),
		.read_data(read_data)
	);

endmodule

`default_nettype wire

// ==== verilog/banked_ram.sv ====
`default_nettype none

module banked_ram
	import rpi_bus_pkg::*, memory_map_pkg::*;
#(
	parameter int DATA_WIDTH = data_width_default,
	parameter int BANK_ADDRESS_DEPTH = bank_address_depth_default,
	parameter int LOG2_OF_NUMBER_OF_BANKS = log2_number_of_banks_default,
	localparam int ADDRESS_WIDTH = BANK_ADDRESS_DEPTH + LOG2_OF_NUMBER_OF_BANKS
) (
	input wire clock,
	input wire mem_enable,
	input wire mem_write,
	input wire [ADDRESS_WIDTH-1:0] mem_address,
	input wire [DATA_WIDTH-1:0] mem_write_data,
	output logic [DATA_WIDTH-1:0] read_data
);
	localparam int NUMBER_OF_BANKS = 1 << LOG2_OF_NUMBER_OF_BANKS;
	localparam int BANK_DEPTH = 1 << BANK_ADDRESS_DEPTH;

	logic [LOG2_OF_NUMBER_OF_BANKS-1:0] bank;
	logic [BANK_ADDRESS_DEPTH-1:0] word_address;
	logic [LOG2_OF_NUMBER_OF_BANKS-1:0] bank_read_select;
	wire [DATA_WIDTH-1:0] bank_read_data [NUMBER_OF_BANKS];

	// upper bits pick the bank
	assign {bank, word_address} = mem_address;

	for (genvar b = 0; b < NUMBER_OF_BANKS; b++) begin : g_bank
		logic [DATA_WIDTH-1:0] storage [BANK_DEPTH];
		logic [DATA_WIDTH-1:0] bank_output;
		logic write_strobe;
		logic read_strobe;

		// one bank decoded per access
		assign write_strobe = mem_enable & mem_write & (bank == LOG2_OF_NUMBER_OF_BANKS'(b));
		assign read_strobe = mem_enable & ~mem_write & (bank == LOG2_OF_NUMBER_OF_BANKS'(b));

		always_ff @(posedge clock) begin
			if (write_strobe) begin
				storage[word_address] <= mem_write_data;
			end
			if (read_strobe) begin
				bank_output <= storage[word_address];
			end
		end

		assign bank_read_data[b] = bank_output;
	end

	// remember which bank answers next cycle
	always_ff @(posedge clock) begin
		if (mem_enable && !mem_write) begin
			bank_read_select <= bank;
		end
	end

	assign read_data = bank_read_data[bank_read_select];

endmodule

`default_nettype wire

// ==== verilog/bank_arbiter.sv ====
`default_nettype none

module bank_arbiter
	import rpi_bus_pkg::*, memory_map_pkg::*;
#(
	parameter int DATA_WIDTH = data_width_default,
	parameter int BANK_ADDRESS_DEPTH = bank_address_depth_default,
	parameter int LOG2_OF_NUMBER_OF_BANKS = log2_number_of_banks_default,
	localparam int ADDRESS_WIDTH = BANK_ADDRESS_DEPTH + LOG2_OF_NUMBER_OF_BANKS
) (
	input wire clock,
	input wire arst_n,
	// host port
	input wire host_request,
	input wire host_write,
	input wire [ADDRESS_WIDTH-1:0] host_address,
	input wire [DATA_WIDTH-1:0] host_write_data,
	output logic host_grant,
	output logic host_read_valid,
	// log port, writes only
	input wire log_request,
	input wire [ADDRESS_WIDTH-1:0] log_address,
	input wire [DATA_WIDTH-1:0] log_record,
	output logic log_grant,
	// single memory port
	output logic mem_enable,
	output logic mem_write,
	output logic [ADDRESS_WIDTH-1:0] mem_address,
	output logic [DATA_WIDTH-1:0] mem_write_data
);

	// ------------------------------
	// grant, host first
	// ------------------------------
	assign host_grant = host_request;
	assign log_grant = log_request & ~host_request;

	// steer the winner to the ram
	always_comb begin
		mem_enable = host_request | log_request;
		if (host_request) begin
			mem_write = host_write;
			mem_address = host_address;
			mem_write_data = host_write_data;
		end else begin
			// logger never reads
			mem_write = log_request;
			mem_address = log_address;
			mem_write_data = log_record;
		end
	end

	// ------------------------------
	// read marker
	// ------------------------------
	// ram data lands one cycle after the grant
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			host_read_valid <= 1'b0;
		end else begin
			host_read_valid <= host_grant & ~host_write;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/edge_logger.sv ====
`default_nettype none

module edge_logger
	import memory_map_pkg::*;
#(
	parameter int BANK_ADDRESS_DEPTH = bank_address_depth_default,
	parameter int LOG2_OF_NUMBER_OF_BANKS = log2_number_of_banks_default,
	localparam int ADDRESS_WIDTH = BANK_ADDRESS_DEPTH + LOG2_OF_NUMBER_OF_BANKS
) (
	input wire clock,
	input wire arst_n,
	input wire [channel_count-1:0] coax_in,
	output logic log_request,
	output logic [ADDRESS_WIDTH-1:0] log_address,
	output log_record_t log_record,
	input wire log_grant
);
	logic [channel_count-1:0] coax_stage1;
	logic [channel_count-1:0] coax_stage2;
	logic [channel_count-1:0] coax_previous;
	logic [channel_count-1:0] coax_rise;
	logic [timestamp_width-1:0] timestamp;
	logic [BANK_ADDRESS_DEPTH-1:0] log_pointer;
	logic retire;

	assign coax_rise = coax_stage2 & ~coax_previous;
	// pending record goes out this cycle
	assign retire = log_request & log_grant;
	assign log_address = {LOG2_OF_NUMBER_OF_BANKS'(log_bank), log_pointer};

	// ------------------------------
	// sync, edges, timestamp, pointer
	// ------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			coax_stage1 <= '0;
			coax_stage2 <= '0;
			coax_previous <= '0;
			timestamp <= '0;
			log_pointer <= '0;
			log_request <= 1'b0;
		end else begin
			coax_stage1 <= coax_in;
			coax_stage2 <= coax_stage1;
			coax_previous <= coax_stage2;
			timestamp <= timestamp + 1'b1;
			// wraps inside the log bank
			if (retire) begin
				log_pointer <= log_pointer + 1'b1;
			end
			if (|coax_rise) begin
				log_request <= 1'b1;
			end else if (retire) begin
				log_request <= 1'b0;
			end
		end
	end

	// ------------------------------
	// pending record
	// ------------------------------
	always_ff @(posedge clock) begin
		if (|coax_rise) begin
			if (log_request && !log_grant) begin
				// still waiting, merge into the mask
				log_record.mask <= log_record.mask | coax_rise;
			end else begin
				log_record.timestamp <= timestamp;
				log_record.mask <= coax_rise;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/half_duplex_rpi_bus.sv ====
`default_nettype none

module half_duplex_rpi_bus
	import rpi_bus_pkg::*, memory_map_pkg::*;
#(
	parameter int BUS_WIDTH = bus_width_default,
	parameter int DATA_WIDTH = data_width_default,
	parameter int BANK_ADDRESS_DEPTH = bank_address_depth_default,
	parameter int LOG2_OF_NUMBER_OF_BANKS = log2_number_of_banks_default,
	parameter bit ADDRESS_AUTOINCREMENT_MODE = 1'b1,
	localparam int ADDRESS_WIDTH = BANK_ADDRESS_DEPTH + LOG2_OF_NUMBER_OF_BANKS
) (
	input wire clock,
	input wire arst_n,
	input wire [BUS_WIDTH-1:0] bus_in,
	output logic [BUS_WIDTH-1:0] bus_out,
	output logic bus_oe,
	input wire read,
	input wire register_select,
	input wire enable,
	output logic ack_valid,
	output logic host_request,
	output logic host_write,
	output logic [ADDRESS_WIDTH-1:0] host_address,
	output logic [DATA_WIDTH-1:0] host_write_data,
	input wire host_grant,
	input wire host_read_valid,
	input wire [DATA_WIDTH-1:0] read_data
);
	localparam int TRANSACTIONS = DATA_WIDTH / BUS_WIDTH;
	localparam int HALF_WIDTH = (TRANSACTIONS > 1) ? $clog2(TRANSACTIONS) : 1;
	localparam logic [HALF_WIDTH-1:0] LAST_HALF = HALF_WIDTH'(TRANSACTIONS - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_read_wait,
		st_acked
	} state_t;

	state_t state;
	logic [2:0] sync_stage1;
	logic [2:0] sync_stage2;
	logic enable_previous;
	logic read_sync;
	logic select_sync;
	logic enable_sync;
	logic start;
	logic is_read;
	logic is_data;
	logic [1:0] current_kind;
	logic [1:0] last_kind;
	logic [HALF_WIDTH-1:0] half;
	logic [HALF_WIDTH-1:0] half_now;
	logic [ADDRESS_WIDTH-1:0] address_reg;
	logic [DATA_WIDTH-1:0] read_latch;

	// ------------------------------
	// host level synchronizer
	// ------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			sync_stage1 <= '0;
			sync_stage2 <= '0;
			enable_previous <= 1'b0;
		end else begin
			sync_stage1 <= {read, register_select, enable};
			sync_stage2 <= sync_stage1;
			enable_previous <= sync_stage2[0];
		end
	end

	assign read_sync = sync_stage2[2];
	assign select_sync = sync_stage2[1];
	assign enable_sync = sync_stage2[0];
	// a new transaction only from idle
	assign start = (state == st_idle) && enable_sync && !enable_previous;
	assign is_read = (read_sync == read_dir);
	assign is_data = (select_sync == select_data);
	assign current_kind = {read_sync, select_sync};
	// other direction or register restarts the word
	assign half_now = (current_kind == last_kind) ? half : '0;
	assign host_address = address_reg;

	// ------------------------------
	// transaction fsm
	// ------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			ack_valid <= 1'b0;
			bus_oe <= 1'b0;
			host_request <= 1'b0;
			host_write <= 1'b0;
			address_reg <= '0;
			half <= '0;
			last_kind <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						last_kind <= current_kind;
						if (!is_data) begin
							// address register, one transaction
							half <= '0;
							bus_oe <= is_read;
							if (!is_read) begin
								address_reg <= bus_in[ADDRESS_WIDTH-1:0];
							end
							ack_valid <= 1'b1;
							state <= st_acked;
						end else if (!is_read) begin
							if (half_now == LAST_HALF) begin
								// word complete, go write it
								host_request <= 1'b1;
								host_write <= 1'b1;
								state <= st_request;
							end else begin
								half <= half_now + 1'b1;
								ack_valid <= 1'b1;
								state <= st_acked;
							end
						end else if (half_now == '0) begin
							// first read half fetches the word
							host_request <= 1'b1;
							host_write <= 1'b0;
							state <= st_request;
						end else begin
							// later halves from the latch
							bus_oe <= 1'b1;
							ack_valid <= 1'b1;
							state <= st_acked;
							if (half_now == LAST_HALF) begin
								half <= '0;
								if (ADDRESS_AUTOINCREMENT_MODE) begin
									address_reg <= address_reg + 1'b1;
								end
							end else begin
								half <= half_now + 1'b1;
							end
						end
					end
				end
				st_request: begin
					// request held until granted
					if (host_grant) begin
						host_request <= 1'b0;
						if (host_write) begin
							half <= '0;
							ack_valid <= 1'b1;
							state <= st_acked;
							// carries on into the bank bits
							if (ADDRESS_AUTOINCREMENT_MODE) begin
								address_reg <= address_reg + 1'b1;
							end
						end else begin
							state <= st_read_wait;
						end
					end
				end
				st_read_wait: begin
					if (host_read_valid) begin
						bus_oe <= 1'b1;
						ack_valid <= 1'b1;
						state <= st_acked;
						if (LAST_HALF == '0) begin
							half <= '0;
							if (ADDRESS_AUTOINCREMENT_MODE) begin
								address_reg <= address_reg + 1'b1;
							end
						end else begin
							half <= HALF_WIDTH'(1);
						end
					end
				end
				default: begin
					// hold ack until the host lets go
					if (!enable_sync) begin
						ack_valid <= 1'b0;
						bus_oe <= 1'b0;
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// ------------------------------
	// data path
	// ------------------------------
	always_ff @(posedge clock) begin
		if (start && is_data && !is_read) begin
			// big-endian assembly, high half first
			host_write_data <= (host_write_data << BUS_WIDTH) | DATA_WIDTH'(bus_in);
		end
		if (start && !is_data && is_read) begin
			bus_out <= BUS_WIDTH'(address_reg);
		end
		if (start && is_data && is_read && half_now != '0) begin
			bus_out <= read_latch[DATA_WIDTH-1 -: BUS_WIDTH];
			read_latch <= read_latch << BUS_WIDTH;
		end
		if (state == st_read_wait && host_read_valid) begin
			bus_out <= read_data[DATA_WIDTH-1 -: BUS_WIDTH];
			read_latch <= read_data << BUS_WIDTH;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/memory_map_pkg.sv ====
`default_nettype none

package memory_map_pkg;

	// ------------------------------
	// bank layout
	// ------------------------------

	// word address bits inside one bank
	localparam int bank_address_depth_default = 13;

	// upper address bits pick the bank, eight banks
	localparam int log2_number_of_banks_default = 3;

	// logger owns the last bank
	localparam int log_bank = 7;

	// ------------------------------
	// log record layout
	// ------------------------------

	// free-running cycle count at the edge
	localparam int timestamp_width = 28;

	// coax inputs watched by the logger
	localparam int channel_count = 4;

	// timestamp on top, channel mask in the low bits
	typedef struct packed {
		logic [timestamp_width-1:0] timestamp;
		logic [channel_count-1:0] mask;
	} log_record_t;

endpackage

`default_nettype wire

// ==== verilog/rpi_bus_pkg.sv ====
`default_nettype none

package rpi_bus_pkg;

	// ------------------------------
	// host bus geometry
	// ------------------------------

	// parallel lines between host and fpga
	localparam int bus_width_default = 16;

	// high half first, then low half
	localparam int transactions_per_data_word_default = 2;

	// one memory word
	localparam int data_width_default = 32;

	// ------------------------------
	// host control levels
	// ------------------------------

	// read level
	localparam logic read_dir = 1'b1;
	localparam logic write_dir = 1'b0;

	// register_select level
	localparam logic select_address = 1'b0;
	localparam logic select_data = 1'b1;

endpackage

`default_nettype wire
